/* lockLcdPkg.sv */
`default_nettype none

package lockLcdPkg;

	// screens the panel logic can request, in table order
	typedef enum logic [2:0]
	{
		doorLocked      = 3'd0,
		accessGranted   = 3'd1,
		accessDenied    = 3'd2,
		roomFull        = 3'd3,
		confirmCapacity = 3'd4,
		idAdded         = 3'd5
	} screen_e;

	localparam int NUM_SCREENS = 6;

	localparam int ID_DIGITS = 9;

	// one nibble per digit, top nibble is the leftmost digit on the glass
	typedef logic [ID_DIGITS-1:0][3:0] idDigits_t;

	typedef struct packed
	{
		screen_e    screen;
		idDigits_t  enteredId;
		logic [7:0] roomCapacity;  // two digit nibbles
	} screenReq_t;

	// one write on the LCD bus
	typedef struct packed
	{
		logic       rs;    // 0 command, 1 character
		logic [7:0] data;
	} lcdWord_t;

	localparam int INIT_LEN = 4;

	localparam lcdWord_t INIT_CMDS [INIT_LEN] = '{
		'{rs: 1'b0, data: 8'h38},  // function set, 8-bit bus, two lines
		'{rs: 1'b0, data: 8'h0C},  // display on, no cursor
		'{rs: 1'b0, data: 8'h01},  // clear screen
		'{rs: 1'b0, data: 8'h06}   // entry mode, increment
	};

	localparam logic [7:0] LINE1_ADDR = 8'h80;  // DDRAM address of line 1
	localparam logic [7:0] LINE2_ADDR = 8'hC0;  // DDRAM address of line 2

	localparam int LINE_COLS = 16;

	// address + line 1 + address + line 2
	localparam int WRITES_PER_SCREEN = 2 * (LINE_COLS + 1);

	localparam logic [7:0] DIGIT_BASE = 8'h30;  // ascii '0'

	localparam int ID_COL  = 5;   // first ID digit on line 2
	localparam int CAP_COL = 14;  // first capacity digit on line 2

	// one full line of text, leftmost character in the top byte
	typedef logic [8*LINE_COLS-1:0] lineText_t;

	// field columns are left blank here and filled in by the ROM
	localparam lineText_t SCREEN_TEXT [NUM_SCREENS][2] = '{
		'{" Door Locked    ", " Enter valid ID "},  // doorLocked
		'{" Access Granted ", " ID:            "},  // accessGranted
		'{" Access Denied  ", " Try Again      "},  // accessDenied
		'{" Access Denied  ", " Room is Full   "},  // roomFull
		'{" Press enter to ", " Confirm Num:   "},  // confirmCapacity
		'{"    ID added    ", "                "}   // idAdded
	};

endpackage

`default_nettype wire

/* lcdBusWriter.sv */
`default_nettype none

module lcdBusWriter
	import lockLcdPkg::*;
#(
	parameter int EN_PULSE_CYCLES = 1,
	parameter int SETTLE_CYCLES   = 262142
)
(
	input  wire             iCLK,
	input  wire             iRST_N,
	input  wire lcdWord_t   word,
	input  wire             wordValid,
	output logic            wordReady,
	output logic [7:0]      lcdData,
	output logic            lcdRs,
	output logic            lcdRw,
	output logic            lcdEn
);

	// one counter serves both the strobe and the settle wait
	localparam int LONGEST = (EN_PULSE_CYCLES > SETTLE_CYCLES) ? EN_PULSE_CYCLES
		: SETTLE_CYCLES;
	localparam int CNT_W = (LONGEST < 1) ? 1 : $clog2(LONGEST + 1);

	typedef enum logic [1:0]
	{
		wrIdle   = 2'd0,
		wrStrobe = 2'd1,
		wrSettle = 2'd2
	} wrPhase_e;

	wrPhase_e         phase;
	logic [CNT_W-1:0] cnt;
	lcdWord_t         held;  // word on the bus pins

	assign wordReady = (phase == wrIdle);

	assign lcdData = held.data;
	assign lcdRs   = held.rs;
	assign lcdRw   = 1'b0;  // write only, busy flag never read

	always_ff @(posedge iCLK or negedge iRST_N)
	begin
		if (!iRST_N)
		begin
			phase <= wrIdle;
			cnt   <= '0;
			held  <= '0;
			lcdEn <= 1'b0;
		end
		else
		begin
			case (phase)
				wrIdle:
				begin
					if (wordValid && wordReady)
					begin
						held  <= word;  // data and rs set up one cycle before enable
						cnt   <= CNT_W'(EN_PULSE_CYCLES);
						phase <= wrStrobe;
					end
				end
				wrStrobe:
				begin
					if (cnt == '0)
					begin
						lcdEn <= 1'b0;  // falling edge latches the LCD
						if (SETTLE_CYCLES == 0)
							phase <= wrIdle;
						else
						begin
							cnt   <= CNT_W'(SETTLE_CYCLES - 1);
							phase <= wrSettle;
						end
					end
					else
					begin
						lcdEn <= 1'b1;
						cnt   <= cnt - 1'b1;
					end
				end
				wrSettle:
				begin
					// controller needs time to execute the write
					if (cnt == '0)
						phase <= wrIdle;
					else
						cnt <= cnt - 1'b1;
				end
				default:
				begin
					lcdEn <= 1'b0;
					phase <= wrIdle;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

/* screenRom.sv */
`default_nettype none

module screenRom
	import lockLcdPkg::*;
(
	input  wire screenReq_t req,
	input  wire [5:0]       pos,
	output lcdWord_t        word
);

	// position of the line 2 address command in a screen
	localparam logic [5:0] LINE2_POS = 6'(LINE_COLS + 1);

	logic       onLine2;
	logic [5:0] rel;
	logic [3:0] col;
	logic       knownScreen;
	logic       idField;
	logic       capField;
	logic [3:0] idIdx;
	logic [3:0] nibble;
	logic [7:0] textChar;

	always_comb
	begin
		onLine2 = (pos > LINE2_POS);
		rel     = onLine2 ? (pos - LINE2_POS - 6'd1) : (pos - 6'd1);
		col     = rel[3:0];  // column on the current line

		knownScreen = (int'(req.screen) < NUM_SCREENS);

		idField = onLine2
			&& (req.screen == accessGranted || req.screen == idAdded)
			&& (col >= 4'(ID_COL))
			&& (col < 4'(ID_COL + ID_DIGITS));

		capField = onLine2
			&& (req.screen == confirmCapacity)
			&& (col >= 4'(CAP_COL));

		// column ID_COL shows the top nibble
		idIdx = 4'(ID_COL + ID_DIGITS - 1) - col;

		if (idField)
			nibble = req.enteredId[idIdx];
		else if (col == 4'(CAP_COL))
			nibble = req.roomCapacity[7:4];  // tens
		else
			nibble = req.roomCapacity[3:0];  // units

		if (knownScreen)
			textChar = SCREEN_TEXT[req.screen][onLine2][8*(LINE_COLS-1-int'(col)) +: 8];
		else
			textChar = 8'h20;  // blank for unused codes
	end

	always_comb
	begin
		if (pos == 6'd0)
			word = '{rs: 1'b0, data: LINE1_ADDR};
		else if (pos == LINE2_POS)
			word = '{rs: 1'b0, data: LINE2_ADDR};
		else if (idField || capField)
			// no clamp, nibbles above 9 show as ':' to '?'
			word = '{rs: 1'b1, data: DIGIT_BASE + {4'h0, nibble}};
		else
			word = '{rs: 1'b1, data: textChar};
	end

endmodule

`default_nettype wire

/* lcdSequencer.sv */
`default_nettype none

module lcdSequencer
	import lockLcdPkg::*;
(
	input  wire             iCLK,
	input  wire             iRST_N,
	input  wire screenReq_t req,
	input  wire             reqValid,
	input  wire lcdWord_t   romWord,
	input  wire             wordReady,
	output logic            reqReady,
	output screenReq_t      curReq,
	output logic [5:0]      pos,
	output lcdWord_t        word,
	output logic            wordValid
);

	typedef enum logic [1:0]
	{
		seqInit   = 2'd0,
		seqIdle   = 2'd1,
		seqScreen = 2'd2
	} seqPhase_e;

	seqPhase_e  phase;
	logic [5:0] idx;        // words already handed to the writer
	logic [5:0] burstLen;   // words in the current burst
	logic       burstDone;
	logic       xfer;

	assign xfer      = wordValid && wordReady;
	assign burstLen  = (phase == seqInit) ? 6'(INIT_LEN) : 6'(WRITES_PER_SCREEN);
	assign burstDone = (idx == burstLen);

	// panel may ask for a screen only when the bus is quiet
	assign reqReady = (phase == seqIdle);

	assign pos = idx;

	always_comb
	begin
		if (phase == seqInit)
			word = INIT_CMDS[idx[1:0]];
		else
			word = romWord;
	end

	always_ff @(posedge iCLK or negedge iRST_N)
	begin
		if (!iRST_N)
		begin
			phase     <= seqInit;
			idx       <= '0;
			wordValid <= 1'b0;
		end
		else
		begin
			case (phase)
				seqInit, seqScreen:
				begin
					if (xfer)
					begin
						wordValid <= 1'b0;
						idx       <= idx + 6'd1;
					end
					else if (!wordValid && wordReady)
					begin
						// writer is free again after the last strobe and settle
						if (burstDone)
						begin
							phase <= seqIdle;
							idx   <= '0;
						end
						else
							wordValid <= 1'b1;
					end
				end
				seqIdle:
				begin
					if (reqValid)
						phase <= seqScreen;
				end
				default:
				begin
					wordValid <= 1'b0;
					idx       <= '0;
					phase     <= seqIdle;
				end
			endcase
		end
	end

	// fields frozen at acceptance, later changes on req do not reach the screen
	always_ff @(posedge iCLK)
	begin
		if (reqValid && reqReady)
			curReq <= req;
	end

endmodule

`default_nettype wire

/* lockLcdTop.sv */
`default_nettype none

module lockLcdTop
	import lockLcdPkg::*;
#(
	parameter int EN_PULSE_CYCLES = 1,
	parameter int SETTLE_CYCLES   = 262142
)
(
	input  wire             iCLK,
	input  wire             iRST_N,
	input  wire screenReq_t req,
	input  wire             reqValid,
	output wire             reqReady,
	output wire [7:0]       lcdData,
	output wire             lcdRs,
	output wire             lcdRw,
	output wire             lcdEn
);

	screenReq_t curReq;     // request being drawn
	logic [5:0] pos;
	lcdWord_t   romWord;
	lcdWord_t   seqWord;
	logic       wordValid;
	logic       wordReady;

	lcdSequencer i_lcdSequencer
	(
		.iCLK      (iCLK),
		.iRST_N    (iRST_N),
		.req       (req),
		.reqValid  (reqValid),
		.romWord   (romWord),
		.wordReady (wordReady),
		.reqReady  (reqReady),
		.curReq    (curReq),
		.pos       (pos),
		.word      (seqWord),
		.wordValid (wordValid)
	);

	screenRom i_screenRom
	(
		.req  (curReq),
		.pos  (pos),
		.word (romWord)
	);

	lcdBusWriter #(
		.EN_PULSE_CYCLES (EN_PULSE_CYCLES),
		.SETTLE_CYCLES   (SETTLE_CYCLES)
	) i_lcdBusWriter
	(
		.iCLK      (iCLK),
		.iRST_N    (iRST_N),
		.word      (seqWord),
		.wordValid (wordValid),
		.wordReady (wordReady),
		.lcdData   (lcdData),
		.lcdRs     (lcdRs),
		.lcdRw     (lcdRw),
		.lcdEn     (lcdEn)
	);

endmodule

`default_nettype wire

/* lockLcd_asserts.sv */
`default_nettype none

module lockLcdAsserts #(
	parameter int EN_PULSE_CYCLES = 1
)
(
	input wire       iCLK,
	input wire       iRST_N,
	input wire       reqReady,
	input wire [7:0] lcdData,
	input wire       lcdRs,
	input wire       lcdRw,
	input wire       lcdEn
);

	int enRun;  // consecutive cycles with enable high

	always_ff @(posedge iCLK or negedge iRST_N)
	begin
		if (!iRST_N)
			enRun <= 0;
		else if (lcdEn)
			enRun <= enRun + 1;
		else
			enRun <= 0;
	end

	rwLow: assert property (@(posedge iCLK) disable iff (!iRST_N) !lcdRw)
		else $error("lcdRw went high on a write-only bus");

	busStable: assert property (@(posedge iCLK) disable iff (!iRST_N)
		lcdEn |-> $stable({lcdRs, lcdData}))
		else $error("lcdData or lcdRs changed while lcdEn was high");

	pulseShort: assert property (@(posedge iCLK) disable iff (!iRST_N)
		$fell(lcdEn) |-> enRun == EN_PULSE_CYCLES)
		else $error("enable pulse shorter than EN_PULSE_CYCLES");

	pulseLong: assert property (@(posedge iCLK) disable iff (!iRST_N)
		lcdEn |-> enRun < EN_PULSE_CYCLES)
		else $error("enable pulse longer than EN_PULSE_CYCLES");

	// no new screen may start mid strobe
	readyQuiet: assert property (@(posedge iCLK) disable iff (!iRST_N) lcdEn |-> !reqReady)
		else $error("reqReady high while lcdEn was high");

endmodule

bind lockLcdTop lockLcdAsserts #(.EN_PULSE_CYCLES(EN_PULSE_CYCLES)) i_lockLcdAsserts
(
	.iCLK     (iCLK),
	.iRST_N   (iRST_N),
	.reqReady (reqReady),
	.lcdData  (lcdData),
	.lcdRs    (lcdRs),
	.lcdRw    (lcdRw),
	.lcdEn    (lcdEn)
);

`default_nettype wire

/* lockLcdTb.sv */
`default_nettype none

module lockLcdTb
	import lockLcdPkg::*;
();

	localparam int NUM_ROWS = 8;
	localparam int SCREEN_WRITES = 34;
	localparam int LIMIT = 38 * NUM_ROWS * (1 + 2 + 3 + 2) + 16 + 200;  // cycles
	localparam logic [31:0] SEED = 32'h5262_4eb5;
	localparam logic [7:0] INIT_EXPECT [4] = '{8'h38, 8'h0C, 8'h01, 8'h06};

	typedef struct packed
	{
		screen_e        screen;
		logic [35:0]    id;         // nine digits, leftmost on top
		logic [7:0]     cap;
		logic           fromLfsr;   // draw id and cap from the LFSR
		logic [255:0]   text;       // both lines, fields blank
	} testRow_t;

	logic       iCLK = 1'b0;
	logic       iRST_N;
	screenReq_t req;
	logic       reqValid;
	wire        reqReady;
	wire [7:0]  lcdData;
	wire        lcdRs;
	wire        lcdRw;
	wire        lcdEn;

	testRow_t    rows [NUM_ROWS];
	lcdWord_t    rxWords [$];  // every strobe seen on the bus
	logic [31:0] lfsr;
	int          cycleCnt = 0;

	lockLcdTop #(
		.EN_PULSE_CYCLES (2),
		.SETTLE_CYCLES   (3)
	) i_lockLcdTop
	(
		.iCLK     (iCLK),
		.iRST_N   (iRST_N),
		.req      (req),
		.reqValid (reqValid),
		.reqReady (reqReady),
		.lcdData  (lcdData),
		.lcdRs    (lcdRs),
		.lcdRw    (lcdRw),
		.lcdEn    (lcdEn)
	);

	always #2 iCLK = ~iCLK;

	// LCD latches on the falling enable
	always @(negedge lcdEn)
	begin
		if (iRST_N)
			rxWords.push_back('{rs: lcdRs, data: lcdData});
	end

	always @(posedge iCLK)
	begin
		cycleCnt <= cycleCnt + 1;
		if (cycleCnt >= LIMIT)
		begin
			$display("Timeout: the DUT did not finish all screens within %0d cycles", LIMIT);
			failRun();
		end
	end

	task automatic failRun();
		$display("Result: FAILED");
		$fatal(1, "stopping at the first error");
	endtask

	function automatic logic [31:0] stepLfsr(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // x^32 + x^22 + x^2 + x + 1
	endfunction

	task automatic drawBits(input int n, output logic [35:0] v);
		int b;
		v = '0;
		for (b = 0; b < n; b++)
		begin
			lfsr = stepLfsr(lfsr);
			v    = {v[34:0], lfsr[0]};
		end
	endtask

	task automatic loadRows();
		logic [35:0] r;
		int i;
		rows[0] = '{doorLocked, 36'h0, 8'h00, 1'b0, {" Door Locked    ", " Enter valid ID "}};
		rows[1] = '{accessGranted, 36'h9AB0C1DEF, 8'h00, 1'b0,
			{" Access Granted ", " ID:            "}};
		rows[2] = '{accessDenied, 36'h0, 8'h00, 1'b0, {" Access Denied  ", " Try Again      "}};
		rows[3] = '{roomFull, 36'h0, 8'h00, 1'b0, {" Access Denied  ", " Room is Full   "}};
		rows[4] = '{confirmCapacity, 36'h0, 8'h42, 1'b0,
			{" Press enter to ", " Confirm Num:   "}};
		rows[5] = '{idAdded, 36'h0, 8'h00, 1'b1, {"    ID added    ", "                "}};
		rows[6] = '{accessGranted, 36'h0, 8'h00, 1'b1,
			{" Access Granted ", " ID:            "}};
		rows[7] = '{confirmCapacity, 36'h0, 8'h00, 1'b1,
			{" Press enter to ", " Confirm Num:   "}};
		for (i = 0; i < NUM_ROWS; i++)
		begin
			if (rows[i].fromLfsr)
			begin
				drawBits(36, r);
				rows[i].id = r;
				drawBits(8, r);
				rows[i].cap = r[7:0];
			end
		end
	endtask

	function automatic screenReq_t toReq(input testRow_t row);
		return '{screen: row.screen, enteredId: row.id, roomCapacity: row.cap};
	endfunction

	function automatic lcdWord_t expectedWord(input testRow_t row, input int k);
		int line;
		int col;
		logic [7:0] ch;
		if (k == 0)
			return '{rs: 1'b0, data: 8'h80};
		if (k == 17)
			return '{rs: 1'b0, data: 8'hC0};
		line = (k > 17) ? 1 : 0;
		col  = (line == 1) ? k - 18 : k - 1;
		ch   = row.text[8 * (31 - 16 * line - col) +: 8];
		if (line == 1 && (row.screen == accessGranted || row.screen == idAdded)
			&& col >= 5 && col <= 13)
			ch = 8'h30 + {4'h0, row.id[4 * (13 - col) +: 4]};  // leftmost digit at col 5
		if (line == 1 && row.screen == confirmCapacity && col >= 14)
			ch = 8'h30 + {4'h0, row.cap[4 * (15 - col) +: 4]};
		return '{rs: 1'b1, data: ch};
	endfunction

	task automatic checkCount(input string name, input int expected);
		assert (rxWords.size() == expected)
		else
		begin
			$display("** Error %s: expected %0d strobes, got %0d", name, expected,
				rxWords.size());
			failRun();
		end
	endtask

	task automatic checkWord(input string name, input int k, input lcdWord_t exp,
		input lcdWord_t got);
		assert (got === exp)
		else
		begin
			$display("** Error %s word %0d: expected rs=%b data=%h, got rs=%b data=%h",
				name, k, exp.rs, exp.data, got.rs, got.data);
			failRun();
		end
	endtask

	task automatic checkScreen(input testRow_t row, input int base, input string name);
		int k;
		for (k = 0; k < SCREEN_WRITES; k++)
			checkWord(name, k, expectedWord(row, k), rxWords[base + k]);
	endtask

	// values are read right after the edge, before the DUT updates
	task automatic waitAccept();
		do
			@(posedge iCLK);
		while (!(reqValid && reqReady));
	endtask

	task automatic waitIdle();
		do
			@(posedge iCLK);
		while (!reqReady);
	endtask

	initial
	begin
		string names [NUM_ROWS];
		screen_e scr;
		int i;
		int k;
		iRST_N   = 1'b0;
		reqValid = 1'b0;
		req      = '0;
		lfsr     = SEED;
		loadRows();
		for (i = 0; i < NUM_ROWS; i++)
		begin
			scr      = rows[i].screen;
			names[i] = $sformatf("row%0d %s", i, scr.name());
		end
		repeat (16) @(posedge iCLK);
		iRST_N   <= 1'b1;
		req      <= toReq(rows[0]);
		reqValid <= 1'b1;  // held through init, must wait for it
		for (i = 0; i < NUM_ROWS; i++)
		begin
			waitAccept();
			checkCount(names[i], 4 + SCREEN_WRITES * i);
			if (i == 0)
			begin
				for (k = 0; k < 4; k++)
					checkWord("init", k, '{rs: 1'b0, data: INIT_EXPECT[k]}, rxWords[k]);
			end
			else
				checkScreen(rows[i - 1], 4 + SCREEN_WRITES * (i - 1), names[i - 1]);
			if (i + 1 < NUM_ROWS)
				req <= toReq(rows[i + 1]);  // next request waits while this screen runs
			else
			begin
				reqValid <= 1'b0;
				req      <= ~toReq(rows[i]);  // scramble fields after capture
			end
		end
		waitIdle();
		checkCount("final", 4 + SCREEN_WRITES * NUM_ROWS);
		checkScreen(rows[NUM_ROWS - 1], 4 + SCREEN_WRITES * (NUM_ROWS - 1), names[NUM_ROWS - 1]);
		$display("Result: PASSED");
		$finish;
	end

endmodule

`default_nettype wire

/* lockLcd.f */
lockLcdPkg.sv
lcdBusWriter.sv
screenRom.sv
lcdSequencer.sv
lockLcdTop.sv
lockLcd_asserts.sv
lockLcdTb.sv

/* Makefile */
TOP = lockLcdTb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f lockLcd.f -o simv
	@out="$$(./obj_dir/simv)"; \
	echo "$$out"; \
	echo "$$out" | grep -q '^Result: PASSED$$'

clean:
	rm -rf obj_dir
